//--- verilog/xbar_pkg.sv
/*
  Shared sizes, fixed address map and enums for the 2x2 request/response crossbar.
  Modules pull these in with a wildcard import in their header.
*/
package xbar_pkg;

  localparam int N_INIT = 2;
  localparam int N_TGT  = 2;

  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int ID_W   = 2;
  localparam int TID_W  = ID_W + 1; // Top bit carries the initiator index

  localparam int REQ_DEPTH   = 2; // Initiator buffer depth, also its credits
  localparam int TGT_CREDITS = 2;
  localparam int RSP_DEPTH   = 2; // Per-target response buffer, also target credits
  localparam int CRD_W       = $clog2(TGT_CREDITS + 1);

  // Packed payload widths: opcode/status bit on top, data at the bottom
  localparam int REQ_W = 1 + ADDR_W + ID_W + DATA_W;
  localparam int RSP_W = 1 + TID_W + DATA_W;

  // Fixed map, a hit is (addr & MASK) == BASE
  localparam logic [ADDR_W-1:0] TGT0_BASE = 16'h0000;
  localparam logic [ADDR_W-1:0] TGT0_MASK = 16'hC000;
  localparam logic [ADDR_W-1:0] TGT1_BASE = 16'h4000;
  localparam logic [ADDR_W-1:0] TGT1_MASK = 16'hC000;

  typedef enum logic {
    OP_READ,
    OP_WRITE
  } op_e;

  typedef enum logic {
    RSP_OKAY,
    RSP_DECERR
  } rsp_e;

  typedef enum logic {
    ERR_IDLE,
    ERR_RESP
  } err_state_e;

endpackage

//--- verilog/credit_fifo.sv
/*
  Small ring buffer for the credit-based channels.
  Each popped entry gives one credit pulse back to the upstream sender.
*/
`timescale 1ns/100ps

module credit_fifo #(
  parameter int W     = 8,
  parameter int DEPTH = 2
) (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         push_i,
  input  logic [W-1:0] push_data_i,
  output logic         full_o,
  input  logic         pop_i,
  output logic [W-1:0] pop_data_o,
  output logic         empty_o,
  output logic         credit_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [W-1:0]     mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             do_push;
  logic             do_pop;

  assign full_o     = (count_q == (PTR_W+1)'(DEPTH));
  assign empty_o    = (count_q == '0);
  assign do_push    = push_i && !full_o;
  assign do_pop     = pop_i && !empty_o;
  assign credit_o   = do_pop;          // Same cycle as the pop
  assign pop_data_o = mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

//--- verilog/addr_decode.sv
/*
  Decodes a request address against the fixed map in the package.
  Gives the target index, or flags a decode error when no range matches.
*/
`timescale 1ns/100ps

module addr_decode import xbar_pkg::*; (
  input  logic [ADDR_W-1:0] addr_i,
  output logic              idx_o,
  output logic              dec_error_o
);

  logic hit0;
  logic hit1;

  assign hit0 = ((addr_i & TGT0_MASK) == TGT0_BASE);
  assign hit1 = ((addr_i & TGT1_MASK) == TGT1_BASE);

  // Ranges do not overlap, so target 1 wins only on its own hit
  assign idx_o       = hit1;
  assign dec_error_o = !(hit0 || hit1);

endmodule

//--- verilog/xbar_demux.sv
/*
  Initiator-side block: buffers requests behind credits, decodes the head entry
  and steers it to a target mux or the error target. Responses from all sources
  are merged, error target first, into a registered initiator response.
*/
`timescale 1ns/100ps

module xbar_demux import xbar_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              init_req_valid_i,
  input  op_e               init_req_op_i,
  input  logic [ADDR_W-1:0] init_req_addr_i,
  input  logic [ID_W-1:0]   init_req_id_i,
  input  logic [DATA_W-1:0] init_req_data_i,
  output logic              init_req_credit_o,
  output logic              init_rsp_valid_o,
  output logic [ID_W-1:0]   init_rsp_id_o,
  output logic [DATA_W-1:0] init_rsp_data_o,
  output rsp_e              init_rsp_status_o,
  output logic [N_TGT-1:0]  req_valid_o,
  input  logic [N_TGT-1:0]  req_ready_i,
  output op_e               req_op_o,
  output logic [ADDR_W-1:0] req_addr_o,
  output logic [ID_W-1:0]   req_id_o,
  output logic [DATA_W-1:0] req_data_o,
  input  logic [N_TGT-1:0]  rsp_valid_i,
  input  logic [ID_W-1:0]   rsp_id_i     [N_TGT],
  input  logic [DATA_W-1:0] rsp_data_i   [N_TGT],
  input  rsp_e              rsp_status_i [N_TGT],
  output logic [N_TGT-1:0]  rsp_ready_o,
  output logic              err_req_valid_o,
  input  logic              err_req_ready_i,
  input  logic              err_rsp_valid_i,
  input  logic [ID_W-1:0]   err_rsp_id_i,
  input  rsp_e              err_rsp_status_i,
  output logic              err_rsp_ready_o
);

  logic [REQ_W-1:0]  head;
  logic              head_empty;
  logic              head_ready;
  logic              head_pop;
  logic              dec_idx;
  logic              dec_err;
  logic              sel_valid;
  logic [ID_W-1:0]   sel_id;
  logic [DATA_W-1:0] sel_data;
  rsp_e              sel_status;

  credit_fifo #(
    .W     (REQ_W),
    .DEPTH (REQ_DEPTH)
  ) i_req_fifo (
    .clk_i,
    .rst_n_i,
    .push_i      (init_req_valid_i),
    .push_data_i ({init_req_op_i, init_req_addr_i, init_req_id_i, init_req_data_i}),
    .full_o      (),
    .pop_i       (head_pop),
    .pop_data_o  (head),
    .empty_o     (head_empty),
    .credit_o    (init_req_credit_o)
  );

  // Head fields go out to every mux and to the error target
  assign req_data_o = head[DATA_W-1:0];
  assign req_id_o   = head[DATA_W +: ID_W];
  assign req_addr_o = head[DATA_W+ID_W +: ADDR_W];
  assign req_op_o   = op_e'(head[REQ_W-1]);

  addr_decode i_addr_decode (
    .addr_i      (req_addr_o),
    .idx_o       (dec_idx),
    .dec_error_o (dec_err)
  );

  always_comb begin
    for (int t = 0; t < N_TGT; t++) begin
      req_valid_o[t] = !head_empty && !dec_err && (dec_idx == 1'(t));
    end
  end

  assign err_req_valid_o = !head_empty && dec_err;
  assign head_ready      = dec_err ? err_req_ready_i : req_ready_i[dec_idx];
  assign head_pop        = !head_empty && head_ready; // Frees a slot, returns a credit

  // Fixed priority merge, error target then target 0, 1
  always_comb begin
    sel_valid       = 1'b0;
    sel_id          = err_rsp_id_i;
    sel_data        = '0;
    sel_status      = err_rsp_status_i;
    err_rsp_ready_o = 1'b0;
    rsp_ready_o     = '0;
    if (err_rsp_valid_i) begin
      sel_valid       = 1'b1;
      err_rsp_ready_o = 1'b1;
    end else begin
      for (int t = 0; t < N_TGT; t++) begin
        if (rsp_valid_i[t] && !sel_valid) begin
          sel_valid      = 1'b1;
          rsp_ready_o[t] = 1'b1;
          sel_id         = rsp_id_i[t];
          sel_data       = rsp_data_i[t];
          sel_status     = rsp_status_i[t];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      init_rsp_valid_o <= 1'b0;
    end else begin
      init_rsp_valid_o <= sel_valid; // Initiator never stalls a response
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_valid) begin
      init_rsp_id_o     <= sel_id;
      init_rsp_data_o   <= sel_data;
      init_rsp_status_o <= sel_status;
    end
  end

endmodule

//--- verilog/xbar_err_target.sv
/*
  Terminates requests whose address hits no target.
  Takes one request at a time and answers one cycle later with a decode error.
*/
`timescale 1ns/100ps

module xbar_err_target import xbar_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            req_valid_i,
  output logic            req_ready_o,
  input  op_e             req_op_i,
  input  logic [ID_W-1:0] req_id_i,
  output logic            rsp_valid_o,
  input  logic            rsp_ready_i,
  output logic [ID_W-1:0] rsp_id_o,
  output rsp_e            rsp_status_o
);

  err_state_e state_q;
  err_state_e state_d;
  logic       accept;

  assign req_ready_o  = (state_q == ERR_IDLE);
  // Reads and writes are both terminated here
  assign accept       = req_valid_i && req_ready_o;
  assign rsp_valid_o  = (state_q == ERR_RESP);
  assign rsp_status_o = RSP_DECERR; // Data is zero, filled in by the demux

  always_comb begin
    state_d = state_q;
    case (state_q)
      ERR_IDLE: if (accept)      state_d = ERR_RESP;
      ERR_RESP: if (rsp_ready_i) state_d = ERR_IDLE;
      default:                   state_d = ERR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ERR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Hold the ID until the response is taken
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_id_o <= req_id_i;
    end
  end

endmodule

//--- verilog/xbar_mux.sv
/*
  Target-side block: round-robin arbitration among initiators, gated by the
  target's request credits. The initiator index is prefixed to the ID on the way
  out and stripped again to route buffered responses back.
*/
`timescale 1ns/100ps

module xbar_mux import xbar_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic [N_INIT-1:0] req_valid_i,
  input  op_e               req_op_i   [N_INIT],
  input  logic [ADDR_W-1:0] req_addr_i [N_INIT],
  input  logic [ID_W-1:0]   req_id_i   [N_INIT],
  input  logic [DATA_W-1:0] req_data_i [N_INIT],
  output logic [N_INIT-1:0] req_ready_o,
  output logic              tgt_req_valid_o,
  output op_e               tgt_req_op_o,
  output logic [ADDR_W-1:0] tgt_req_addr_o,
  output logic [TID_W-1:0]  tgt_req_id_o,
  output logic [DATA_W-1:0] tgt_req_data_o,
  input  logic              tgt_req_credit_i,
  input  logic              tgt_rsp_valid_i,
  input  logic [TID_W-1:0]  tgt_rsp_id_i,
  input  logic [DATA_W-1:0] tgt_rsp_data_i,
  input  rsp_e              tgt_rsp_status_i,
  output logic              tgt_rsp_credit_o,
  output logic [N_INIT-1:0] rsp_valid_o,
  output logic [ID_W-1:0]   rsp_id_o,
  output logic [DATA_W-1:0] rsp_data_o,
  output rsp_e              rsp_status_o,
  input  logic [N_INIT-1:0] rsp_ready_i
);

  logic [CRD_W-1:0]  credit_cnt_q;
  logic              can_send;
  logic [N_INIT-1:0] gnt;
  logic              gnt_idx;
  logic              last_q;
  logic [RSP_W-1:0]  rsp_head;
  logic [TID_W-1:0]  head_tid;
  logic              rsp_empty;
  logic              rsp_pop;

  // Credits are spent when the request leaves, so hold one back for the pending send
  assign can_send = (credit_cnt_q > CRD_W'(tgt_req_valid_o));

  always_comb begin
    int cand;
    cand    = 0;
    gnt     = '0;
    gnt_idx = 1'b0;
    if (can_send) begin
      // Start after the last winner
      for (int k = 1; k <= N_INIT; k++) begin
        cand = (int'(last_q) + k) % N_INIT;
        if (req_valid_i[cand] && (gnt == '0)) begin
          gnt[cand] = 1'b1;
          gnt_idx   = 1'(cand);
        end
      end
    end
  end

  assign req_ready_o = gnt;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_cnt_q    <= CRD_W'(TGT_CREDITS);
      last_q          <= 1'b1;   // Initiator 0 goes first
      tgt_req_valid_o <= 1'b0;
    end else begin
      credit_cnt_q    <= credit_cnt_q + CRD_W'(tgt_req_credit_i) - CRD_W'(tgt_req_valid_o);
      tgt_req_valid_o <= |gnt;
      if (|gnt) begin
        last_q <= gnt_idx;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (|gnt) begin
      tgt_req_op_o   <= req_op_i[gnt_idx];
      tgt_req_addr_o <= req_addr_i[gnt_idx];
      tgt_req_id_o   <= {gnt_idx, req_id_i[gnt_idx]}; // Extended ID
      tgt_req_data_o <= req_data_i[gnt_idx];
    end
  end

  credit_fifo #(
    .W     (RSP_W),
    .DEPTH (RSP_DEPTH)
  ) i_rsp_fifo (
    .clk_i,
    .rst_n_i,
    .push_i      (tgt_rsp_valid_i),
    .push_data_i ({tgt_rsp_status_i, tgt_rsp_id_i, tgt_rsp_data_i}),
    .full_o      (),
    .pop_i       (rsp_pop),
    .pop_data_o  (rsp_head),
    .empty_o     (rsp_empty),
    .credit_o    (tgt_rsp_credit_o)
  );

  assign rsp_data_o   = rsp_head[DATA_W-1:0];
  assign head_tid     = rsp_head[DATA_W +: TID_W];
  assign rsp_status_o = rsp_e'(rsp_head[RSP_W-1]);
  assign rsp_id_o     = head_tid[ID_W-1:0];    // Index bit stripped

  always_comb begin
    for (int k = 0; k < N_INIT; k++) begin
      rsp_valid_o[k] = !rsp_empty && (head_tid[TID_W-1] == 1'(k));
    end
  end

  assign rsp_pop = |(rsp_valid_o & rsp_ready_i);

endmodule

//--- verilog/xbar_top.sv
/*
  Top of the 2x2 crossbar: one demux and error target per initiator, one mux per
  target, and the crossing wires between them.
*/
`timescale 1ns/100ps

module xbar_top import xbar_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic [N_INIT-1:0] init_req_valid_i,
  input  op_e               init_req_op_i     [N_INIT],
  input  logic [ADDR_W-1:0] init_req_addr_i   [N_INIT],
  input  logic [ID_W-1:0]   init_req_id_i     [N_INIT],
  input  logic [DATA_W-1:0] init_req_data_i   [N_INIT],
  output logic [N_INIT-1:0] init_req_credit_o,
  output logic [N_INIT-1:0] init_rsp_valid_o,
  output logic [ID_W-1:0]   init_rsp_id_o     [N_INIT],
  output logic [DATA_W-1:0] init_rsp_data_o   [N_INIT],
  output rsp_e              init_rsp_status_o [N_INIT],
  output logic [N_TGT-1:0]  tgt_req_valid_o,
  output op_e               tgt_req_op_o      [N_TGT],
  output logic [ADDR_W-1:0] tgt_req_addr_o    [N_TGT],
  output logic [TID_W-1:0]  tgt_req_id_o      [N_TGT],
  output logic [DATA_W-1:0] tgt_req_data_o    [N_TGT],
  input  logic [N_TGT-1:0]  tgt_req_credit_i,
  input  logic [N_TGT-1:0]  tgt_rsp_valid_i,
  input  logic [TID_W-1:0]  tgt_rsp_id_i      [N_TGT],
  input  logic [DATA_W-1:0] tgt_rsp_data_i    [N_TGT],
  input  rsp_e              tgt_rsp_status_i  [N_TGT],
  output logic [N_TGT-1:0]  tgt_rsp_credit_o
);

  // Demux side, indexed by initiator
  logic [N_TGT-1:0]  d_req_valid [N_INIT];
  logic [N_TGT-1:0]  d_req_ready [N_INIT];
  op_e               d_req_op    [N_INIT];
  logic [ADDR_W-1:0] d_req_addr  [N_INIT];
  logic [ID_W-1:0]   d_req_id    [N_INIT];
  logic [DATA_W-1:0] d_req_data  [N_INIT];
  logic [N_TGT-1:0]  d_rsp_valid [N_INIT];
  logic [N_TGT-1:0]  d_rsp_ready [N_INIT];
  // Mux side, indexed by target
  logic [N_INIT-1:0] m_req_valid  [N_TGT];
  logic [N_INIT-1:0] m_req_ready  [N_TGT];
  logic [N_INIT-1:0] m_rsp_valid  [N_TGT];
  logic [N_INIT-1:0] m_rsp_ready  [N_TGT];
  logic [ID_W-1:0]   m_rsp_id     [N_TGT];
  logic [DATA_W-1:0] m_rsp_data   [N_TGT];
  rsp_e              m_rsp_status [N_TGT];
  // Error target links
  logic [N_INIT-1:0] e_req_valid;
  logic [N_INIT-1:0] e_req_ready;
  logic [N_INIT-1:0] e_rsp_valid;
  logic [N_INIT-1:0] e_rsp_ready;
  logic [ID_W-1:0]   e_rsp_id     [N_INIT];
  rsp_e              e_rsp_status [N_INIT];

  for (genvar i = 0; i < N_INIT; i++) begin : gen_init
    xbar_demux i_demux (
      .clk_i,
      .rst_n_i,
      .init_req_valid_i  (init_req_valid_i[i]),
      .init_req_op_i     (init_req_op_i[i]),
      .init_req_addr_i   (init_req_addr_i[i]),
      .init_req_id_i     (init_req_id_i[i]),
      .init_req_data_i   (init_req_data_i[i]),
      .init_req_credit_o (init_req_credit_o[i]),
      .init_rsp_valid_o  (init_rsp_valid_o[i]),
      .init_rsp_id_o     (init_rsp_id_o[i]),
      .init_rsp_data_o   (init_rsp_data_o[i]),
      .init_rsp_status_o (init_rsp_status_o[i]),
      .req_valid_o       (d_req_valid[i]),
      .req_ready_i       (d_req_ready[i]),
      .req_op_o          (d_req_op[i]),
      .req_addr_o        (d_req_addr[i]),
      .req_id_o          (d_req_id[i]),
      .req_data_o        (d_req_data[i]),
      .rsp_valid_i       (d_rsp_valid[i]),
      .rsp_id_i          (m_rsp_id),      // Response payloads are shared by all demuxes
      .rsp_data_i        (m_rsp_data),
      .rsp_status_i      (m_rsp_status),
      .rsp_ready_o       (d_rsp_ready[i]),
      .err_req_valid_o   (e_req_valid[i]),
      .err_req_ready_i   (e_req_ready[i]),
      .err_rsp_valid_i   (e_rsp_valid[i]),
      .err_rsp_id_i      (e_rsp_id[i]),
      .err_rsp_status_i  (e_rsp_status[i]),
      .err_rsp_ready_o   (e_rsp_ready[i])
    );

    xbar_err_target i_err_target (
      .clk_i,
      .rst_n_i,
      .req_valid_i  (e_req_valid[i]),
      .req_ready_o  (e_req_ready[i]),
      .req_op_i     (d_req_op[i]),
      .req_id_i     (d_req_id[i]),
      .rsp_valid_o  (e_rsp_valid[i]),
      .rsp_ready_i  (e_rsp_ready[i]),
      .rsp_id_o     (e_rsp_id[i]),
      .rsp_status_o (e_rsp_status[i])
    );

    for (genvar j = 0; j < N_TGT; j++) begin : gen_cross
      assign m_req_valid[j][i] = d_req_valid[i][j];
      assign d_req_ready[i][j] = m_req_ready[j][i];
      assign d_rsp_valid[i][j] = m_rsp_valid[j][i];
      assign m_rsp_ready[j][i] = d_rsp_ready[i][j];
    end
  end

  for (genvar j = 0; j < N_TGT; j++) begin : gen_tgt
    xbar_mux i_mux (
      .clk_i,
      .rst_n_i,
      .req_valid_i      (m_req_valid[j]),
      .req_op_i         (d_req_op),
      .req_addr_i       (d_req_addr),
      .req_id_i         (d_req_id),
      .req_data_i       (d_req_data),
      .req_ready_o      (m_req_ready[j]),
      .tgt_req_valid_o  (tgt_req_valid_o[j]),
      .tgt_req_op_o     (tgt_req_op_o[j]),
      .tgt_req_addr_o   (tgt_req_addr_o[j]),
      .tgt_req_id_o     (tgt_req_id_o[j]),
      .tgt_req_data_o   (tgt_req_data_o[j]),
      .tgt_req_credit_i (tgt_req_credit_i[j]),
      .tgt_rsp_valid_i  (tgt_rsp_valid_i[j]),
      .tgt_rsp_id_i     (tgt_rsp_id_i[j]),
      .tgt_rsp_data_i   (tgt_rsp_data_i[j]),
      .tgt_rsp_status_i (tgt_rsp_status_i[j]),
      .tgt_rsp_credit_o (tgt_rsp_credit_o[j]),
      .rsp_valid_o      (m_rsp_valid[j]),
      .rsp_id_o         (m_rsp_id[j]),
      .rsp_data_o       (m_rsp_data[j]),
      .rsp_status_o     (m_rsp_status[j]),
      .rsp_ready_i      (m_rsp_ready[j])
    );
  end

endmodule

//--- dv/tb_clkgen.sv
/*
  Testbench clock and reset source: 8 ns clock, reset held low for 5 cycles
  and released on a falling edge.
*/
`timescale 1ns/100ps

module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o) rst_n_o = 1'b1;
  end

endmodule

//--- dv/xbar_assert.sv
/*
  Concurrent checks on one target mux, attached to every xbar_mux by bind.
  Covers the credit counter, credit-gated sends and the response credits.
*/
`timescale 1ns/100ps

module xbar_assert import xbar_pkg::*; (
  input logic              clk_i,
  input logic              rst_n_i,
  input logic [CRD_W-1:0]  credit_cnt_q,
  input logic              tgt_req_valid_o,
  input logic              tgt_rsp_valid_i,
  input logic              tgt_rsp_credit_o,
  input logic [N_INIT-1:0] rsp_valid_o
);

  int rsp_used_q; // Responses sitting in the buffer

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_used_q <= 0;
    end else begin
      rsp_used_q <= rsp_used_q + int'(tgt_rsp_valid_i) - int'(tgt_rsp_credit_o);
    end
  end

  credit_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credit_cnt_q <= CRD_W'(TGT_CREDITS))
    else $error("mux credit count above the pool size");

  no_send_without_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tgt_req_valid_o |-> (credit_cnt_q != '0))
    else $error("target request sent with zero credits");

  // Targets push only into a free slot of the response buffer
  rsp_push_with_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tgt_rsp_valid_i |-> (rsp_used_q < RSP_DEPTH))
    else $error("target response pushed without a response credit");

  quiet_after_reset: assert property (@(posedge clk_i)
    (!rst_n_i ##1 rst_n_i) |-> (!tgt_req_valid_o && !tgt_rsp_credit_o && rsp_valid_o == '0))
    else $error("valid or credit output high right after reset");

endmodule

//--- dv/xbar_tb.sv
/*
  Testbench for the 2x2 crossbar. Random initiators and target models run three
  phases (mixed traffic, target 1 withholding credits, contention on target 0)
  and a scoreboard checks routing, data, status and IDs of every response.
*/
`timescale 1ns/100ps

module xbar_tb import xbar_pkg::*; ();

  localparam int NPH    = 50;             // Requests per initiator per phase
  localparam int NTOTAL = 3 * N_INIT * NPH;
  localparam int NID    = 1 << ID_W;

  logic              clk;
  logic              rst_n;
  logic [N_INIT-1:0] init_req_valid;
  op_e               init_req_op   [N_INIT];
  logic [ADDR_W-1:0] init_req_addr [N_INIT];
  logic [ID_W-1:0]   init_req_id   [N_INIT];
  logic [DATA_W-1:0] init_req_data [N_INIT];
  logic [N_INIT-1:0] init_req_credit;
  logic [N_INIT-1:0] init_rsp_valid;
  logic [ID_W-1:0]   init_rsp_id     [N_INIT];
  logic [DATA_W-1:0] init_rsp_data   [N_INIT];
  rsp_e              init_rsp_status [N_INIT];
  logic [N_TGT-1:0]  tgt_req_valid;
  op_e               tgt_req_op   [N_TGT];
  logic [ADDR_W-1:0] tgt_req_addr [N_TGT];
  logic [TID_W-1:0]  tgt_req_id   [N_TGT];
  logic [DATA_W-1:0] tgt_req_data [N_TGT];
  logic [N_TGT-1:0]  tgt_req_credit;
  logic [N_TGT-1:0]  tgt_rsp_valid;
  logic [TID_W-1:0]  tgt_rsp_id     [N_TGT];
  logic [DATA_W-1:0] tgt_rsp_data   [N_TGT];
  rsp_e              tgt_rsp_status [N_TGT];
  logic [N_TGT-1:0]  tgt_rsp_credit;

  // Scoreboard state, indexed by initiator and ID
  bit                busy     [N_INIT][NID];
  bit                seen     [N_INIT][NID];
  op_e               exp_op   [N_INIT][NID];
  logic [ADDR_W-1:0] exp_addr [N_INIT][NID];
  logic [DATA_W-1:0] exp_data [N_INIT][NID];
  logic [DATA_W-1:0] wr_data  [N_INIT][NID];
  logic [DATA_W-1:0] model_mem [logic [ADDR_W-1:0]];
  int                pend_wr   [logic [ADDR_W-1:0]];
  logic [DATA_W-1:0] tgt_mem   [logic [ADDR_W-1:0]];
  int                route_q [N_INIT][N_TGT][$];  // Issued IDs in order, per target
  logic [REQ_W:0]    tq [N_TGT][$];  // {op, addr, tid, data}
  int                credits [N_INIT];
  int                rsp_credits [N_TGT];
  int                held [N_TGT];
  bit                stall [N_TGT];
  bit                rr_last [N_TGT];
  int                mode;
  int                issued;
  int                done_cnt;
  string             test_name;

  tb_clkgen i_clkgen (.clk_o(clk), .rst_n_o(rst_n));

  xbar_top UUT (
    .clk_i (clk), .rst_n_i (rst_n),
    .init_req_valid_i (init_req_valid), .init_req_op_i (init_req_op),
    .init_req_addr_i (init_req_addr), .init_req_id_i (init_req_id),
    .init_req_data_i (init_req_data), .init_req_credit_o (init_req_credit),
    .init_rsp_valid_o (init_rsp_valid), .init_rsp_id_o (init_rsp_id),
    .init_rsp_data_o (init_rsp_data), .init_rsp_status_o (init_rsp_status),
    .tgt_req_valid_o (tgt_req_valid), .tgt_req_op_o (tgt_req_op),
    .tgt_req_addr_o (tgt_req_addr), .tgt_req_id_o (tgt_req_id),
    .tgt_req_data_o (tgt_req_data), .tgt_req_credit_i (tgt_req_credit),
    .tgt_rsp_valid_i (tgt_rsp_valid), .tgt_rsp_id_i (tgt_rsp_id),
    .tgt_rsp_data_i (tgt_rsp_data), .tgt_rsp_status_i (tgt_rsp_status),
    .tgt_rsp_credit_o (tgt_rsp_credit)
  );

  bind xbar_mux xbar_assert i_assert (.*);

  function automatic logic [DATA_W-1:0] fill_word(logic [ADDR_W-1:0] a);
    return {a ^ 16'hA5C3, ~a}; // Never-written locations
  endfunction

  task automatic abort_run(string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic cmp_status(string what, rsp_e exp, rsp_e act);
    if (exp !== act)
      abort_run($sformatf("** Error %s %s: expected %s actual %s",
                          test_name, what, exp.name(), act.name()));
  endtask

  task automatic cmp_data(string what, logic [DATA_W-1:0] exp, logic [DATA_W-1:0] act);
    if (exp !== act)
      abort_run($sformatf("** Error %s %s: expected %h actual %h", test_name, what, exp, act));
  endtask

  task automatic cmp_id(string what, logic [ID_W-1:0] exp, logic [ID_W-1:0] act);
    if (exp !== act)
      abort_run($sformatf("** Error %s %s: expected %0d actual %0d", test_name, what, exp, act));
  endtask

  // Both initiators waiting means the last winner must lose
  task automatic check_rr(int j, logic [N_INIT-1:0] v, logic [N_INIT-1:0] g);
    if (g != '0) begin
      if (v == 2'b11 && g[rr_last[j]])
        abort_run($sformatf("Arbiter of target %0d granted the same initiator twice", j));
      rr_last[j] = g[1];
    end
  endtask

  task automatic run_init(input int i, input int n);
    int               sent;
    int               start;
    int               id;
    int               r;
    logic [1:0]       rg;
    logic [ADDR_W-1:0] a;
    op_e              op;
    sent = 0;
    while (sent < n) begin
      @(negedge clk);
      init_req_valid[i] = 1'b0;
      id    = -1;
      start = $urandom % NID;
      for (int k = 0; k < NID; k++)
        if (id < 0 && !busy[i][(start + k) % NID]) id = (start + k) % NID;
      if (credits[i] > 0 && id >= 0 && ($urandom % 4) != 0) begin
        r  = $urandom % 8;
        rg = (mode == 2) ? 2'd0 : (r < 3) ? 2'd0 : (r < 6) ? 2'd1 : (r == 6) ? 2'd2 : 2'd3;
        a  = {rg, 5'd0, 1'(i), 6'd0, 2'($urandom % 4)};  // Bit 8 is the initiator slice
        op = (($urandom % 2) == 0) ? OP_READ : OP_WRITE;
        if (op == OP_READ && pend_wr.exists(a) && pend_wr[a] > 0) op = OP_WRITE;
        busy[i][id]     = 1'b1;
        seen[i][id]     = 1'b0;
        exp_op[i][id]   = op;
        exp_addr[i][id] = a;
        wr_data[i][id]  = $urandom;
        exp_data[i][id] = '0;
        if (op == OP_READ && rg[1] == 1'b0)
          exp_data[i][id] = model_mem.exists(a) ? model_mem[a] : fill_word(a);
        if (op == OP_WRITE && rg[1] == 1'b0)
          pend_wr[a] = pend_wr.exists(a) ? pend_wr[a] + 1 : 1;
        if (rg[1] == 1'b0)
          route_q[i][rg[0]].push_back(id);
        init_req_valid[i] = 1'b1;
        init_req_op[i]    = op;
        init_req_addr[i]  = a;
        init_req_id[i]    = ID_W'(id);
        init_req_data[i]  = wr_data[i][id];
        credits[i]--;
        sent++;
        issued++;
      end
    end
    @(negedge clk) init_req_valid[i] = 1'b0;
  endtask

  // Credit pulses count at the popping edge so a freed slot is reused one cycle later
  always @(posedge clk) begin
    if (rst_n) begin
      for (int i = 0; i < N_INIT; i++)
        if (init_req_credit[i]) credits[i]++;
    end
  end

  // Initiator side: response scoreboard
  always @(negedge clk) begin
    if (rst_n) begin
      for (int i = 0; i < N_INIT; i++) begin
        if (init_rsp_valid[i]) begin
          int          id;
          logic [ADDR_W-1:0] a;
          id = int'(init_rsp_id[i]);
          a  = exp_addr[i][id];
          if (!busy[i][id])
            abort_run($sformatf("Initiator %0d got a response for idle ID %0d", i, id));
          cmp_status("status", (a[15] ? RSP_DECERR : RSP_OKAY), init_rsp_status[i]);
          cmp_data("data", exp_data[i][id], init_rsp_data[i]);
          if (!a[15] && !seen[i][id])
            abort_run("Response arrived for a request that never reached a target");
          if (!a[15] && exp_op[i][id] == OP_WRITE) begin
            model_mem[a] = wr_data[i][id];
            pend_wr[a]   = pend_wr[a] - 1;
          end
          busy[i][id] = 1'b0;
          done_cnt++;
        end
      end
    end
  end

  // Target models: routing checks, memory, credits and random response delay
  always @(negedge clk) begin
    if (rst_n) begin
      check_rr(0, UUT.gen_tgt[0].i_mux.req_valid_i, UUT.gen_tgt[0].i_mux.gnt);
      check_rr(1, UUT.gen_tgt[1].i_mux.req_valid_i, UUT.gen_tgt[1].i_mux.gnt);
      for (int t = 0; t < N_TGT; t++) begin
        logic [REQ_W:0]    e;
        logic [ADDR_W-1:0] a;
        int                i;
        int                id;
        int                exp_id;
        tgt_req_credit[t] = 1'b0;
        tgt_rsp_valid[t]  = 1'b0;
        if (tgt_req_valid[t]) begin
          a  = tgt_req_addr[t];
          i  = int'(tgt_req_id[t][TID_W-1]);
          id = int'(tgt_req_id[t][ID_W-1:0]);
          if (a[15]) abort_run("Undecodable address reached a target");
          if (int'(a[14]) != t) abort_run($sformatf("Address %h routed to target %0d", a, t));
          if (int'(a[8]) != i) abort_run("Extended ID does not name the issuing initiator");
          if (route_q[i][t].size() == 0)
            abort_run("Target received a request that was not issued");
          exp_id = route_q[i][t].pop_front();
          cmp_id("request id", ID_W'(exp_id), tgt_req_id[t][ID_W-1:0]);
          if (!busy[i][id] || exp_addr[i][id] !== a || exp_op[i][id] != tgt_req_op[t])
            abort_run("Target received a request that was not issued");
          cmp_data("request data", wr_data[i][id], tgt_req_data[t]);
          if (seen[i][id]) abort_run("Request delivered to a target twice");
          seen[i][id] = 1'b1;
          held[t]++;
          if (held[t] > TGT_CREDITS) abort_run("Target received more requests than credits");
          tq[t].push_back({tgt_req_op[t], a, tgt_req_id[t], tgt_req_data[t]});
        end
        if (tq[t].size() > 0 && rsp_credits[t] > 0 && !stall[t] && ($urandom % 3) == 0) begin
          e = tq[t].pop_front();
          a = e[DATA_W+TID_W +: ADDR_W];
          tgt_rsp_id[t]     = e[DATA_W +: TID_W];
          tgt_rsp_status[t] = RSP_OKAY;
          tgt_rsp_data[t]   = '0;
          if (e[REQ_W] == 1'b1) tgt_mem[a] = e[DATA_W-1:0];   // Write
          else tgt_rsp_data[t] = tgt_mem.exists(a) ? tgt_mem[a] : fill_word(a);
          tgt_rsp_valid[t]  = 1'b1;
          tgt_req_credit[t] = 1'b1;
          rsp_credits[t]--;
          held[t]--;
        end
        // Returned slot is usable from the next cycle on
        if (tgt_rsp_credit[t]) rsp_credits[t]++;
      end
    end
  end

  initial begin
    repeat (NTOTAL * 40) @(posedge clk);
    abort_run("Watchdog expired before all responses returned");
  end

  initial begin
    void'($urandom(32'h6ffb));
    init_req_valid = '0;
    tgt_req_credit = '0;
    tgt_rsp_valid  = '0;
    for (int i = 0; i < N_INIT; i++) begin
      init_req_op[i]   = OP_READ;
      init_req_addr[i] = '0;
      init_req_id[i]   = '0;
      init_req_data[i] = '0;
      credits[i]       = REQ_DEPTH;
    end
    for (int t = 0; t < N_TGT; t++) begin
      tgt_rsp_id[t]     = '0;
      tgt_rsp_data[t]   = '0;
      tgt_rsp_status[t] = RSP_OKAY;
      rsp_credits[t]    = RSP_DEPTH;
      held[t]           = 0;
      stall[t]          = 1'b0;
      rr_last[t]        = 1'b1;
    end
    issued    = 0;
    done_cnt  = 0;
    mode      = 0;
    test_name = "reset";
    wait (rst_n);
    @(negedge clk);
    if (init_req_credit != '0 || init_rsp_valid != '0 || tgt_req_valid != '0 ||
        tgt_rsp_credit != '0)
      abort_run("Valid or credit output high after reset");

    test_name = "mixed";
    fork
      run_init(0, NPH);
      run_init(1, NPH);
    join
    wait (done_cnt == issued);

    test_name = "credit_stall";
    stall[1] = 1'b1;
    fork
      run_init(0, NPH);
      run_init(1, NPH);
      begin
        repeat (200) @(negedge clk);
        stall[1] = 1'b0;
      end
    join
    wait (done_cnt == issued);

    test_name = "contention";
    mode = 2;
    fork
      run_init(0, NPH);
      run_init(1, NPH);
    join
    wait (done_cnt == issued);
    repeat (4) @(negedge clk);

    if (done_cnt == NTOTAL && credits[0] == REQ_DEPTH && credits[1] == REQ_DEPTH) begin
      $display("*** TEST PASSED ***");
    end else begin
      abort_run("Response count or credits wrong at the end of the run");
    end
    $finish;
  end

endmodule

//--- sources.f
verilog/xbar_pkg.sv
verilog/credit_fifo.sv
verilog/addr_decode.sv
verilog/xbar_demux.sv
verilog/xbar_err_target.sv
verilog/xbar_mux.sv
verilog/xbar_top.sv
dv/tb_clkgen.sv
dv/xbar_assert.sv
dv/xbar_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= xbar_tb
FILELIST  ?= sources.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
